// ==== common/soc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared bus, register and pin types
// 32-bit wishbone classic, one access in flight
// misc registers indexed by adr[6:2]
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_pkg;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// address regions, taken from adr[31:28]
	typedef enum logic [3:0] {
		REGION_MISC = 4'h2,
		REGION_RAM  = 4'h4
	} region_e;

	typedef enum logic [4:0] {
		REG_LED       = 5'd0,
		REG_BTN       = 5'd1,
		REG_SOC_VER   = 5'd2,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_IN  = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE  = 5'd19,
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21,
		REG_GPEXT_IN  = 5'd22,
		REG_GPEXT_OUT = 5'd23,
		REG_GPEXT_OE  = 5'd24,
		REG_GPEXT_W2S = 5'd25,
		REG_GPEXT_W2C = 5'd26
	} misc_reg_e;

	typedef struct packed {
		logic write_out;
		logic write_oe;
		logic set;
		logic clear;
	} gpio_op_t;

	typedef logic [29:0] genio_t;
	typedef logic [7:0]  pmod_t;
	typedef logic [5:0]  sao_t;

	typedef struct packed {
		pmod_t pmod;
		sao_t  sao2;
		sao_t  sao1;
	} gpext_pins_t;

	localparam logic [31:0] BUS_ERROR_DATA = 32'hDEAD_BEEF;
	localparam logic [23:0] RELOAD_MAGIC   = 24'hD0F1A5;
	localparam logic [2:0]  FSEL_DELAY     = 3'd7;

	// bit positions of the extension banks inside a GPEXT word
	localparam int GPEXT_PMOD_POS = 16;
	localparam int GPEXT_SAO2_POS = 8;
	localparam int GPEXT_SAO1_POS = 0;

endpackage

// ==== misc/gpio_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output and enable registers of one bank
// write_out wins over set and clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module gpio_bank #(
	parameter type pin_t = logic [7:0]
) (
	input  logic               clk48m,
	input  logic               rst,
	input  soc_pkg::gpio_op_t  op,
	input  pin_t               wdata,
	output pin_t               pins_out,
	output pin_t               pins_oe
);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			pins_out <= '0;
			pins_oe  <= '0;
		end else begin
			if (op.write_out)
				pins_out <= wdata;
			else if (op.set)
				pins_out <= pins_out | wdata;
			else if (op.clear)
				pins_out <= pins_out & ~wdata;
			if (op.write_oe)
				pins_oe <= wdata;
		end
	end

endmodule

// ==== misc/misc_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// misc register file, region 0x2
// writes need sel lane 0
// unlisted indices read as zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module misc_regs #(
	parameter logic [31:0] SOC_VERSION = 32'h0
) (
	input  logic                  clk48m,
	input  logic                  rst,
	input  soc_pkg::wb_req_t      req,
	output soc_pkg::wb_rsp_t      rsp,
	input  logic [7:0]            btn,
	output logic [8:0]            led,
	input  soc_pkg::genio_t       genio_in,
	output soc_pkg::genio_t       genio_out,
	output soc_pkg::genio_t       genio_oe,
	input  soc_pkg::gpext_pins_t  gpext_in,
	output soc_pkg::gpext_pins_t  gpext_out,
	output soc_pkg::gpext_pins_t  gpext_oe,
	output logic                  fsel_d,
	output logic                  fsel_c,
	output logic                  programn
);

	soc_pkg::misc_reg_e reg_idx;
	soc_pkg::gpio_op_t  genio_op;
	soc_pkg::gpio_op_t  gpext_op;
	soc_pkg::pmod_t     pmod_out, pmod_oe;
	soc_pkg::sao_t      sao2_out, sao2_oe;
	soc_pkg::sao_t      sao1_out, sao1_oe;
	logic [31:0]        rd_mux;
	logic [31:0]        rdata;
	logic               access;
	logic               wr;
	logic               ack;

	// spread the three extension banks over one bus word
	function automatic logic [31:0] pack_gpext(soc_pkg::gpext_pins_t p);
		logic [31:0] w;
		w = '0;
		w[soc_pkg::GPEXT_PMOD_POS +: $bits(soc_pkg::pmod_t)] = p.pmod;
		w[soc_pkg::GPEXT_SAO2_POS +: $bits(soc_pkg::sao_t)]  = p.sao2;
		w[soc_pkg::GPEXT_SAO1_POS +: $bits(soc_pkg::sao_t)]  = p.sao1;
		return w;
	endfunction

	assign reg_idx = soc_pkg::misc_reg_e'(req.adr[6:2]);
	assign access  = req.cyc & req.stb & ~ack;
	assign wr      = access & req.we & req.sel[0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ack <= 1'b0;
			led <= '0;
		end else begin
			ack <= access;
			if (wr && reg_idx == soc_pkg::REG_LED)
				led <= req.dat[8:0];
		end
	end

	// bank operations, GPEXT shares one op across its three banks
	always_comb begin
		genio_op = '0;
		gpext_op = '0;
		if (wr) begin
			case (reg_idx)
				soc_pkg::REG_GENIO_OUT: genio_op.write_out = 1'b1;
				soc_pkg::REG_GENIO_OE:  genio_op.write_oe  = 1'b1;
				soc_pkg::REG_GENIO_W2S: genio_op.set       = 1'b1;
				soc_pkg::REG_GENIO_W2C: genio_op.clear     = 1'b1;
				soc_pkg::REG_GPEXT_OUT: gpext_op.write_out = 1'b1;
				soc_pkg::REG_GPEXT_OE:  gpext_op.write_oe  = 1'b1;
				soc_pkg::REG_GPEXT_W2S: gpext_op.set       = 1'b1;
				soc_pkg::REG_GPEXT_W2C: gpext_op.clear     = 1'b1;
				default: ;
			endcase
		end
	end

	gpio_bank #(.pin_t(soc_pkg::genio_t)) genio_bank0 (
		.clk48m   (clk48m),
		.rst      (rst),
		.op       (genio_op),
		.wdata    (req.dat[$bits(soc_pkg::genio_t)-1:0]),
		.pins_out (genio_out),
		.pins_oe  (genio_oe)
	);

	gpio_bank #(.pin_t(soc_pkg::pmod_t)) pmod_bank0 (
		.clk48m   (clk48m),
		.rst      (rst),
		.op       (gpext_op),
		.wdata    (req.dat[soc_pkg::GPEXT_PMOD_POS +: $bits(soc_pkg::pmod_t)]),
		.pins_out (pmod_out),
		.pins_oe  (pmod_oe)
	);

	gpio_bank #(.pin_t(soc_pkg::sao_t)) sao2_bank0 (
		.clk48m   (clk48m),
		.rst      (rst),
		.op       (gpext_op),
		.wdata    (req.dat[soc_pkg::GPEXT_SAO2_POS +: $bits(soc_pkg::sao_t)]),
		.pins_out (sao2_out),
		.pins_oe  (sao2_oe)
	);

	gpio_bank #(.pin_t(soc_pkg::sao_t)) sao1_bank0 (
		.clk48m   (clk48m),
		.rst      (rst),
		.op       (gpext_op),
		.wdata    (req.dat[soc_pkg::GPEXT_SAO1_POS +: $bits(soc_pkg::sao_t)]),
		.pins_out (sao1_out),
		.pins_oe  (sao1_oe)
	);

	assign gpext_out = '{pmod: pmod_out, sao2: sao2_out, sao1: sao1_out};
	assign gpext_oe  = '{pmod: pmod_oe, sao2: sao2_oe, sao1: sao1_oe};

	reload_seq reload0 (
		.clk48m     (clk48m),
		.rst        (rst),
		.sel_strobe (wr && reg_idx == soc_pkg::REG_FLASH_SEL),
		.wdata      (req.dat),
		.fsel_d     (fsel_d),
		.fsel_c     (fsel_c),
		.programn   (programn)
	);

	// buttons are active low on the board
	always_comb begin
		case (reg_idx)
			soc_pkg::REG_LED:       rd_mux = {23'h0, led};
			soc_pkg::REG_BTN:       rd_mux = {24'h0, ~btn};
			soc_pkg::REG_SOC_VER:   rd_mux = SOC_VERSION;
			soc_pkg::REG_FLASH_SEL: rd_mux = {31'h0, fsel_d};
			soc_pkg::REG_GENIO_IN:  rd_mux = {2'h0, genio_in};
			soc_pkg::REG_GENIO_OUT: rd_mux = {2'h0, genio_out};
			soc_pkg::REG_GENIO_OE:  rd_mux = {2'h0, genio_oe};
			soc_pkg::REG_GPEXT_IN:  rd_mux = pack_gpext(gpext_in);
			soc_pkg::REG_GPEXT_OUT: rd_mux = pack_gpext(gpext_out);
			soc_pkg::REG_GPEXT_OE:  rd_mux = pack_gpext(gpext_oe);
			default:                rd_mux = 32'h0;
		endcase
	end

	always_ff @(posedge clk48m) begin
		if (access)
			rdata <= rd_mux;
	end

	assign rsp.ack = ack;
	assign rsp.dat = rdata;

endmodule

// ==== misc/reload_seq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flash select latch and reload request
// fsel_c is a three-cycle pulse
// programn stays low until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module reload_seq (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        sel_strobe,
	input  logic [31:0] wdata,
	output logic        fsel_d,
	output logic        fsel_c,
	output logic        programn
);

	logic       strobe_q;
	logic       armed;
	logic       reload;
	logic [2:0] delay;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_d   <= 1'b0;
			armed    <= 1'b0;
			strobe_q <= 1'b0;
			delay    <= '0;
			reload   <= 1'b0;
		end else begin
			strobe_q <= sel_strobe;
			if (sel_strobe) begin
				fsel_d <= wdata[0];
				armed  <= (wdata[31:8] == soc_pkg::RELOAD_MAGIC);
			end
			// give the select flop time to settle before reload
			if (strobe_q) begin
				delay <= soc_pkg::FSEL_DELAY;
			end else if (delay != 3'd0) begin
				delay <= delay - 3'd1;
				if (delay == 3'd1 && armed)
					reload <= 1'b1;
			end
		end
	end

	// clock the select flop mid-countdown
	assign fsel_c   = (delay == 3'd5) || (delay == 3'd4) || (delay == 3'd3);
	assign programn = ~reload;

endmodule

// ==== project.f ====
common/soc_pkg.sv
source/bus_decode.sv
source/scratch_ram.sv
misc/gpio_bank.sv
misc/reload_seq.sv
misc/misc_regs.sv
source/soc_top.sv
verif/soc_chk.sv
verif/soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module soc_tb -Mdir "$BUILD_DIR" -f project.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/Vsoc_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$sim_status" -ne 0 ]; then
	echo "simulation ended with status $sim_status"
	exit 1
fi
echo "simulation finished without failure"
exit 0

// ==== source/bus_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// region decode on adr[31:28]
// unmapped accesses get 0xDEADBEEF and
// a one-cycle irq pulse with their ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bus_decode (
	input  logic              clk48m,
	input  logic              rst,
	input  soc_pkg::wb_req_t  wb_req,
	output soc_pkg::wb_rsp_t  wb_rsp,
	output soc_pkg::wb_req_t  misc_req,
	output soc_pkg::wb_req_t  ram_req,
	input  soc_pkg::wb_rsp_t  misc_rsp,
	input  soc_pkg::wb_rsp_t  ram_rsp,
	output logic              bus_error_irq
);

	soc_pkg::region_e region;
	logic             active;
	logic             hit_misc;
	logic             hit_ram;
	logic             err_ack;

	assign region   = soc_pkg::region_e'(wb_req.adr[31:28]);
	assign active   = wb_req.cyc & wb_req.stb;
	assign hit_misc = (region == soc_pkg::REGION_MISC);
	assign hit_ram  = (region == soc_pkg::REGION_RAM);

	// each target sees the whole request, strobe only when selected
	always_comb begin
		misc_req     = wb_req;
		misc_req.stb = active & hit_misc;
		ram_req      = wb_req;
		ram_req.stb  = active & hit_ram;
	end

	// own ack for unmapped regions, same one-cycle shape as the targets
	always_ff @(posedge clk48m) begin
		if (rst) begin
			err_ack <= 1'b0;
		end else begin
			err_ack <= active & ~hit_misc & ~hit_ram & ~err_ack;
		end
	end

	assign bus_error_irq = err_ack;

	// adr is held through the ack cycle, so the region still selects data
	always_comb begin
		wb_rsp.ack = misc_rsp.ack | ram_rsp.ack | err_ack;
		case (region)
			soc_pkg::REGION_MISC: wb_rsp.dat = misc_rsp.dat;
			soc_pkg::REGION_RAM:  wb_rsp.dat = ram_rsp.dat;
			default:              wb_rsp.dat = soc_pkg::BUS_ERROR_DATA;
		endcase
	end

endmodule

// ==== source/scratch_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word RAM with byte lanes
// address wraps modulo RAM_WORDS
// contents are undefined after power-up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic              clk48m,
	input  logic              rst,
	input  soc_pkg::wb_req_t  req,
	output soc_pkg::wb_rsp_t  rsp
);

	localparam int AW = $clog2(RAM_WORDS);

	logic [31:0]   mem [RAM_WORDS];
	logic [31:0]   rdata;
	logic [AW-1:0] idx;
	logic          access;
	logic          ack;

	assign idx    = req.adr[AW+1:2];
	assign access = req.cyc & req.stb & ~ack;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clk48m) begin
		if (access) begin
			rdata <= mem[idx];
			if (req.we) begin
				for (int i = 0; i < 4; i++) begin
					if (req.sel[i])
						mem[idx][8*i +: 8] <= req.dat[8*i +: 8];
				end
			end
		end
	end

	assign rsp.ack = ack;
	assign rsp.dat = rdata;

endmodule

// ==== source/soc_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control-side bus target of the SoC
// master must hold a request until ack
// RAM_WORDS must be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module soc_top #(
	parameter logic [31:0] SOC_VERSION = 32'h0000_8000,
	parameter int          RAM_WORDS   = 256
) (
	input  logic                  clk48m,
	input  logic                  rst,
	input  soc_pkg::wb_req_t      wb_req,
	output soc_pkg::wb_rsp_t      wb_rsp,
	output logic                  bus_error_irq,
	input  logic [7:0]            btn,
	output logic [8:0]            led,
	input  soc_pkg::genio_t       genio_in,
	output soc_pkg::genio_t       genio_out,
	output soc_pkg::genio_t       genio_oe,
	input  soc_pkg::gpext_pins_t  gpext_in,
	output soc_pkg::gpext_pins_t  gpext_out,
	output soc_pkg::gpext_pins_t  gpext_oe,
	output logic                  fsel_d,
	output logic                  fsel_c,
	output logic                  programn
);

	soc_pkg::wb_req_t misc_req;
	soc_pkg::wb_req_t ram_req;
	soc_pkg::wb_rsp_t misc_rsp;
	soc_pkg::wb_rsp_t ram_rsp;

	bus_decode decode0 (
		.clk48m        (clk48m),
		.rst           (rst),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp),
		.misc_req      (misc_req),
		.ram_req       (ram_req),
		.misc_rsp      (misc_rsp),
		.ram_rsp       (ram_rsp),
		.bus_error_irq (bus_error_irq)
	);

	misc_regs #(
		.SOC_VERSION (SOC_VERSION)
	) misc0 (
		.clk48m    (clk48m),
		.rst       (rst),
		.req       (misc_req),
		.rsp       (misc_rsp),
		.btn       (btn),
		.led       (led),
		.genio_in  (genio_in),
		.genio_out (genio_out),
		.genio_oe  (genio_oe),
		.gpext_in  (gpext_in),
		.gpext_out (gpext_out),
		.gpext_oe  (gpext_oe),
		.fsel_d    (fsel_d),
		.fsel_c    (fsel_c),
		.programn  (programn)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) ram0 (
		.clk48m (clk48m),
		.rst    (rst),
		.req    (ram_req),
		.rsp    (ram_rsp)
	);

endmodule

// ==== verif/soc_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus and reload protocol assertions
// bound into every soc_top instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module soc_chk (
	input logic              clk48m,
	input logic              rst,
	input soc_pkg::wb_req_t  wb_req,
	input soc_pkg::wb_rsp_t  wb_rsp,
	input logic              fsel_c,
	input logic              programn
);

	logic [2:0] fsel_c_run;

	// cycles fsel_c has already been high, saturating
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_c_run <= '0;
		end else if (!fsel_c) begin
			fsel_c_run <= '0;
		end else if (fsel_c_run != 3'd7) begin
			fsel_c_run <= fsel_c_run + 3'd1;
		end
	end

	ack_needs_strobe: assert property (@(posedge clk48m) disable iff (rst)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
		else $error("ack seen without cyc and stb");

	ack_single_cycle: assert property (@(posedge clk48m) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("ack high on two consecutive cycles");

	fsel_c_short: assert property (@(posedge clk48m) disable iff (rst)
		fsel_c |-> (fsel_c_run < 3'd3))
		else $error("fsel_c high for more than three cycles");

	programn_sticky: assert property (@(posedge clk48m) disable iff (rst)
		!programn |=> !programn)
		else $error("programn rose again after going low");

endmodule

bind soc_top soc_chk chk0 (
	.clk48m   (clk48m),
	.rst      (rst),
	.wb_req   (wb_req),
	.wb_rsp   (wb_rsp),
	.fsel_c   (fsel_c),
	.programn (programn)
);

// ==== verif/soc_stimulus.txt ====
# name op address data lanes expected, all numbers in hex
# pin op: address picks 0 led 1 genio_out 2 genio_oe 3 gpext_out 4 gpext_oe 5 fsel_d 6 fsel_c 7 programn 8 irq 9 irq_at_last_ack
rst_led        pin   00000000 00000000 0 00000000
rst_genio_out  pin   00000001 00000000 0 00000000
rst_genio_oe   pin   00000002 00000000 0 00000000
rst_gpext_out  pin   00000003 00000000 0 00000000
rst_gpext_oe   pin   00000004 00000000 0 00000000
rst_fsel_d     pin   00000005 00000000 0 00000000
rst_fsel_c     pin   00000006 00000000 0 00000000
rst_programn   pin   00000007 00000000 0 00000001
rst_irq        pin   00000008 00000000 0 00000000
led_write      write 20000000 FFFFF1A5 1 00000000
led_nolane     write 20000000 00000000 E 00000000
led_read       read  20000000 00000000 F 000001A5
led_pins       pin   00000000 00000000 0 000001A5
btn_set        btn   00000000 000000A5 0 00000000
btn_read       read  20000004 00000000 F 0000005A
ver_read       read  20000008 00000000 F 0B1D0007
unlisted_read  read  20000014 00000000 F 00000000
genio_set      genio 00000000 2AAA5555 0 00000000
genio_in_rd    read  20000044 00000000 F 2AAA5555
gpext_set      gpext 00000000 00A53C15 0 00000000
gpext_in_rd    read  20000058 00000000 F 00A53C15
genio_out      write 20000048 0F0F0F0F 1 00000000
genio_w2s      write 20000050 30000003 1 00000000
genio_w2c      write 20000054 0000000F 1 00000000
genio_out_pin  pin   00000001 00000000 0 3F0F0F00
genio_out_rd   read  20000048 00000000 F 3F0F0F00
genio_oe       write 2000004C FFFFFFFF 1 00000000
genio_oe_pin   pin   00000002 00000000 0 3FFFFFFF
gpext_out      write 2000005C 00FF3F00 1 00000000
gpext_w2s      write 20000064 00002A15 1 00000000
gpext_w2c      write 20000068 000F0F01 1 00000000
gpext_out_pin  pin   00000003 00000000 0 00F03014
gpext_out_rd   read  2000005C 00000000 F 00F03014
gpext_oe       write 20000060 00C0C0C0 1 00000000
gpext_oe_pin   pin   00000004 00000000 0 00C00000
ram_full       write 40000010 11223344 F 00000000
ram_lanes02    write 40000010 AABBCCDD 5 00000000
ram_lane3      write 40000010 EE000000 8 00000000
ram_read       read  40000010 00000000 F EEBB33DD
ram_alias      read  40000410 00000000 F EEBB33DD
ram_no_irq     pin   00000009 00000000 0 00000000
err_read       read  90000000 00000000 F DEADBEEF
err_irq        pin   00000009 00000000 0 00000001
fsel_plain     fsel  20000034 00000001 F 00000003
fsel_d_set     pin   00000005 00000000 0 00000001
fsel_read      read  20000034 00000000 F 00000001
fsel_reload    fsel  20000034 D0F1A500 F 00000103
fsel_d_clear   pin   00000005 00000000 0 00000000
programn_low   pin   00000007 00000000 0 00000000

// ==== verif/soc_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for soc_top, driven by a table
// reads verif/soc_stimulus.txt, so run it
// from the project root
// stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module soc_tb;

	localparam int          CLK_PERIOD   = 40;
	localparam int          DRIVE_DELAY  = 2;
	localparam int          ACK_LIMIT    = 4;
	localparam int          STEP_CYCLES  = 50;
	localparam int          FSEL_WINDOW  = 12;
	localparam int          RELOAD_LIMIT = 10;
	localparam int          NAME_W       = 8 * 16;
	localparam logic [31:0] TB_VERSION   = 32'h0B1D_0007;

	// operation words as they appear in the stimulus file
	localparam logic [63:0] OP_WRITE = 64'("write");
	localparam logic [63:0] OP_READ  = 64'("read");
	localparam logic [63:0] OP_PIN   = 64'("pin");
	localparam logic [63:0] OP_BTN   = 64'("btn");
	localparam logic [63:0] OP_GENIO = 64'("genio");
	localparam logic [63:0] OP_GPEXT = 64'("gpext");
	localparam logic [63:0] OP_FSEL  = 64'("fsel");

	logic                 clk48m;
	logic                 rst;
	soc_pkg::wb_req_t     wb_req;
	soc_pkg::wb_rsp_t     wb_rsp;
	logic                 bus_error_irq;
	logic [7:0]           btn;
	logic [8:0]           led;
	soc_pkg::genio_t      genio_in, genio_out, genio_oe;
	soc_pkg::gpext_pins_t gpext_in, gpext_out, gpext_oe;
	logic                 fsel_d, fsel_c, programn;

	logic [NAME_W-1:0] step_name [$];
	logic [63:0]       step_op [$];
	logic [31:0]       step_addr [$];
	logic [31:0]       step_data [$];
	logic [3:0]        step_lanes [$];
	logic [31:0]       step_expect [$];
	logic              loaded;
	logic              irq_at_ack;
	logic [31:0]       rd_data;

	soc_top #(
		.SOC_VERSION (TB_VERSION),
		.RAM_WORDS   (256)
	) dut0 (
		.clk48m        (clk48m),
		.rst           (rst),
		.wb_req        (wb_req),
		.wb_rsp        (wb_rsp),
		.bus_error_irq (bus_error_irq),
		.btn           (btn),
		.led           (led),
		.genio_in      (genio_in),
		.genio_out     (genio_out),
		.genio_oe      (genio_oe),
		.gpext_in      (gpext_in),
		.gpext_out     (gpext_out),
		.gpext_oe      (gpext_oe),
		.fsel_d        (fsel_d),
		.fsel_c        (fsel_c),
		.programn      (programn)
	);

	initial begin
		clk48m = 1'b0;
		forever #(CLK_PERIOD / 2) clk48m = ~clk48m;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [NAME_W-1:0] name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			abort_run($sformatf("** Error %0s: expected 0x%08h, actual 0x%08h",
				name, expected, actual));
	endtask

	// one classic cycle, held through the ack cycle and
	// released at the drive point after the following edge
	task automatic bus_access(input logic we, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] lanes);
		int waited;
		waited = 1;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.sel = lanes;
		wb_req.adr = addr;
		wb_req.dat = data;
		@(posedge clk48m);
		#(DRIVE_DELAY);
		while (!wb_rsp.ack) begin
			assert (waited < ACK_LIMIT) else
				abort_run($sformatf("no ack within %0d cycles at address 0x%08h",
					ACK_LIMIT, addr));
			@(posedge clk48m);
			#(DRIVE_DELAY);
			waited++;
		end
		rd_data    = wb_rsp.dat;
		irq_at_ack = bus_error_irq;
		@(posedge clk48m);
		#(DRIVE_DELAY);
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
	endtask

	// extension pins laid out at their bus word positions
	function automatic logic [31:0] place_gpext(input soc_pkg::gpext_pins_t p);
		logic [31:0] w;
		w = '0;
		w[soc_pkg::GPEXT_PMOD_POS +: $bits(soc_pkg::pmod_t)] = p.pmod;
		w[soc_pkg::GPEXT_SAO2_POS +: $bits(soc_pkg::sao_t)]  = p.sao2;
		w[soc_pkg::GPEXT_SAO1_POS +: $bits(soc_pkg::sao_t)]  = p.sao1;
		return w;
	endfunction

	function automatic logic [31:0] observe_pin(input logic [31:0] which);
		logic [31:0] w;
		case (which)
			32'd0:   w = {23'h0, led};
			32'd1:   w = {2'h0, genio_out};
			32'd2:   w = {2'h0, genio_oe};
			32'd3:   w = place_gpext(gpext_out);
			32'd4:   w = place_gpext(gpext_oe);
			32'd5:   w = {31'h0, fsel_d};
			32'd6:   w = {31'h0, fsel_c};
			32'd7:   w = {31'h0, programn};
			32'd8:   w = {31'h0, bus_error_irq};
			32'd9:   w = {31'h0, irq_at_ack};
			default: w = 'x;
		endcase
		return w;
	endfunction

	// result word: bit 8 reload seen, low byte fsel_c cycles in the window
	task automatic watch_flash_select(input logic [NAME_W-1:0] name, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] lanes, input logic [31:0] expected);
		int c_cycles;
		int low_at;
		c_cycles = 0;
		low_at   = 0;
		bus_access(1'b1, addr, data, lanes);
		// bus_access returns one cycle after the ack, low_at counts from the ack edge
		for (int i = 1; i <= FSEL_WINDOW; i++) begin
			@(posedge clk48m);
			#(DRIVE_DELAY);
			if (fsel_c)
				c_cycles++;
			if (!programn && low_at == 0)
				low_at = i + 1;
		end
		assert (low_at <= RELOAD_LIMIT) else
			abort_run($sformatf("%0s: programn fell %0d cycles after the ack, too late",
				name, low_at));
		check_value(name, expected, {23'h0, low_at != 0, c_cycles[7:0]});
	endtask

	task automatic load_stimulus();
		int                fd;
		int                n;
		string             line;
		logic [NAME_W-1:0] name;
		logic [63:0]       op;
		logic [31:0]       addr, data, expected;
		logic [3:0]        lanes;
		fd = $fopen("verif/soc_stimulus.txt", "r");
		if (fd == 0)
			abort_run("cannot open the stimulus file verif/soc_stimulus.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.substr(0, 0) != "#" && line.substr(0, 0) != "\n") begin
				n = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, data, lanes, expected);
				if (n != 6)
					abort_run({"malformed stimulus line: ", line});
				step_name.push_back(name);
				step_op.push_back(op);
				step_addr.push_back(addr);
				step_data.push_back(data);
				step_lanes.push_back(lanes);
				step_expect.push_back(expected);
			end
		end
		$fclose(fd);
		loaded = 1'b1;
	endtask

	task automatic run_step(input int k);
		logic [NAME_W-1:0] name;
		logic [63:0]       op;
		logic [31:0]       data;
		name = step_name[k];
		op   = step_op[k];
		data = step_data[k];
		case (op)
			OP_WRITE: bus_access(1'b1, step_addr[k], data, step_lanes[k]);
			OP_READ: begin
				bus_access(1'b0, step_addr[k], 32'h0, 4'hF);
				check_value(name, step_expect[k], rd_data);
			end
			OP_PIN:   check_value(name, step_expect[k], observe_pin(step_addr[k]));
			OP_BTN:   btn = data[7:0];
			OP_GENIO: genio_in = data[$bits(soc_pkg::genio_t)-1:0];
			OP_GPEXT: begin
				gpext_in.pmod = data[soc_pkg::GPEXT_PMOD_POS +: $bits(soc_pkg::pmod_t)];
				gpext_in.sao2 = data[soc_pkg::GPEXT_SAO2_POS +: $bits(soc_pkg::sao_t)];
				gpext_in.sao1 = data[soc_pkg::GPEXT_SAO1_POS +: $bits(soc_pkg::sao_t)];
			end
			OP_FSEL:  watch_flash_select(name, step_addr[k], data, step_lanes[k], step_expect[k]);
			default:  abort_run($sformatf("unknown operation %0s in step %0s", op, name));
		endcase
	endtask

	// watchdog, sized from the number of stimulus steps
	initial begin
		wait (loaded);
		repeat (step_op.size() * STEP_CYCLES + 10) @(posedge clk48m);
		abort_run("watchdog expired before the stimulus finished");
	end

	initial begin
		rst        = 1'b1;
		wb_req     = '0;
		btn        = '0;
		genio_in   = '0;
		gpext_in   = '0;
		loaded     = 1'b0;
		irq_at_ack = 1'b0;
		rd_data    = '0;
		load_stimulus();
		repeat (3) @(posedge clk48m);
		#(DRIVE_DELAY);
		rst = 1'b0;
		for (int k = 0; k < step_op.size(); k++)
			run_step(k);
		$display("=== PASS ===");
		$finish;
	end

endmodule
